// ==== common/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Word slots in the alignment buffer queue
`define FETCH_BUF_DEPTH 3

// Width of the whole-instruction counter inside the buffer
`define FETCH_BUF_CNT_W 3

// Non-flushed bus transactions allowed in flight
`define FETCH_MAX_OUTSTANDING 2

// PC and first fetch address after reset
`define FETCH_BOOT_ADDR 32'h0000_0000

`endif

// ==== common/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

  // Byte address on the fetch path
  // Instruction addresses are always halfword aligned
  typedef logic [31:0] fetch_addr_t;

  // Memory word or output instruction
  // A compressed instruction sits in bits 15:0
  typedef logic [31:0] instr_word_t;

  // Bus transactions in flight, or responses left to drop
  typedef logic [2:0] outstanding_cnt_t;

  // Whole instructions held in the alignment buffer
  typedef logic [`FETCH_BUF_CNT_W-1:0] buf_cnt_t;

  // Whole instructions found in one incoming word, 0 to 2
  typedef logic [1:0] ins_cnt_t;

endpackage

// ==== common/fetch_if.sv ====
interface fetch_if import fetch_pkg::*; ();

  // Fetch request side
  logic        fetch_valid;
  logic        fetch_ready;
  logic        fetch_branch;
  fetch_addr_t fetch_branch_addr;

  // Response side, one word per strobe, in request order
  logic        resp_valid;
  instr_word_t resp_rdata;

  modport align_mp (
    output fetch_valid,
    output fetch_branch,
    output fetch_branch_addr,
    input  fetch_ready,
    input  resp_valid,
    input  resp_rdata
  );

  modport pf_mp (
    input  fetch_valid,
    input  fetch_branch,
    input  fetch_branch_addr,
    output fetch_ready,
    output resp_valid,
    output resp_rdata
  );

endinterface

// ==== rtl/alignment_buffer/alignment_buffer.sv ====
`include "fetch_macros.svh"

module alignment_buffer import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        branch_i,
  input  logic        prefetch_en_i,
  input  fetch_addr_t branch_addr_i,
  fetch_if.align_mp   fetch,
  output logic        busy_o,
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output instr_word_t instr_o,
  output fetch_addr_t instr_pc_o
);

  localparam int          DEPTH     = `FETCH_BUF_DEPTH;
  localparam fetch_addr_t BOOT_ADDR = `FETCH_BOOT_ADDR;

  // Word queue, slot 0 feeds the output
  instr_word_t            rdata_q [DEPTH];
  instr_word_t            rdata_int [DEPTH];
  instr_word_t            rdata_n [DEPTH];
  logic [DEPTH-1:0]       valid_q, valid_int, valid_n;

  fetch_addr_t            addr_q, addr_n, addr_incr;
  instr_word_t            rdata_al, rdata_unal;
  logic                   valid_al, valid_unal;
  logic                   al_compressed, unal_compressed;
  logic                   resp_valid, instr_taken;

  // Counters and word-boundary tracking
  buf_cnt_t               fifo_cnt_q, fifo_cnt_n;
  outstanding_cnt_t       outstanding_q, outstanding_n;
  outstanding_cnt_t       n_flush_q, n_flush_n, nonflush_cnt;
  ins_cnt_t               n_incoming;
  logic                   aligned_q, aligned_n, complete_q, complete_n;
  logic                   upper_compressed, want_word, accepted;
  logic                   req_hold_q, br_wait_q;

  // Responses from before a branch are dropped here
  assign resp_valid  = (n_flush_q == '0) && fetch.resp_valid;
  assign instr_taken = instr_valid_o && instr_ready_i;

  //////////////////////////////////////////////////
  // Fetch requests
  //////////////////////////////////////////////////

  assign nonflush_cnt = outstanding_q - n_flush_q;

  // Refill when empty, or nearly empty with nothing on the way
  assign want_word = ((fifo_cnt_q == '0) &&
                      (nonflush_cnt < outstanding_cnt_t'(`FETCH_MAX_OUTSTANDING))) ||
                     ((fifo_cnt_q == buf_cnt_t'(1)) && (nonflush_cnt == '0));

  // A request stays up until the prefetcher takes it
  assign fetch.fetch_valid = branch_i || br_wait_q ||
                             (prefetch_en_i && (req_hold_q || want_word));
  assign fetch.fetch_branch      = branch_i;
  assign fetch.fetch_branch_addr = {branch_addr_i[31:2], 2'b00};
  assign accepted = fetch.fetch_valid && fetch.fetch_ready;

  assign busy_o = (outstanding_q != '0) || fetch.fetch_valid;

  //////////////////////////////////////////////////
  // Output selection
  //////////////////////////////////////////////////

  // Aligned data comes from slot 0 or straight from the bus
  assign rdata_al = valid_q[0] ? rdata_q[0] : fetch.resp_rdata;
  assign valid_al = valid_q[0] || resp_valid;

  // Unaligned joins upper half of slot 0 with the next lower half
  assign rdata_unal = valid_q[1] ? {rdata_q[1][15:0], rdata_al[31:16]}
                                 : {fetch.resp_rdata[15:0], rdata_al[31:16]};
  assign valid_unal = valid_q[1] || (valid_q[0] && resp_valid);

  assign al_compressed   = rdata_al[1:0] != 2'b11;
  assign unal_compressed = rdata_al[17:16] != 2'b11;

  always_comb begin
    instr_o       = rdata_al;
    instr_valid_o = 1'b0;
    // Nothing is offered in a branch cycle
    if (!branch_i) begin
      if (addr_q[1]) begin
        instr_o       = rdata_unal;
        instr_valid_o = valid_al && (unal_compressed || valid_unal);
      end else begin
        instr_valid_o = valid_al;
      end
    end
  end

  assign instr_pc_o = addr_q;

  //////////////////////////////////////////////////
  // Queue update
  //////////////////////////////////////////////////

  // Incoming word goes to the first free slot
  always_comb begin : push_slot
    logic placed;
    placed    = 1'b0;
    rdata_int = rdata_q;
    valid_int = valid_q;
    if (resp_valid) begin
      for (int j = 0; j < DEPTH; j++) begin
        if (!valid_q[j] && !placed) begin
          rdata_int[j] = fetch.resp_rdata;
          valid_int[j] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;

  // Advance PC, shift out a word once it is used up
  always_comb begin : pop_slot
    logic shift;
    shift   = 1'b0;
    addr_n  = addr_q;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (instr_taken) begin
      if (addr_q[1]) begin
        // Slot 0 is always used up from an odd halfword
        addr_n = unal_compressed ? addr_incr : {addr_incr[31:2], 2'b10};
        shift  = 1'b1;
      end else if (al_compressed) begin
        addr_n = {addr_q[31:2], 2'b10};
      end else begin
        addr_n = addr_incr;
        shift  = 1'b1;
      end
    end
    if (shift) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        rdata_n[i] = rdata_int[i+1];
        valid_n[i] = valid_int[i+1];
      end
      valid_n[DEPTH-1] = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Instruction counting
  //////////////////////////////////////////////////

  assign upper_compressed = fetch.resp_rdata[17:16] != 2'b11;

  // Whole instructions completed by each accepted word
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      // Odd target, low half of the first word is skipped
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_valid) begin
      if (aligned_q && (fetch.resp_rdata[1:0] == 2'b11)) begin
        n_incoming = 2'd1;
      end else begin
        aligned_n  = upper_compressed;
        complete_n = upper_compressed;
        if (!aligned_q && complete_q) begin
          n_incoming = upper_compressed ? 2'd1 : 2'd0;
        end else begin
          // Low half finishes one, upper half may hold another
          n_incoming = upper_compressed ? 2'd2 : 2'd1;
        end
      end
    end
  end

  assign fifo_cnt_n = branch_i ? '0
                               : fifo_cnt_q + buf_cnt_t'(n_incoming) - buf_cnt_t'(instr_taken);

  // Outstanding count and responses left to drop
  always_comb begin
    outstanding_n = outstanding_q;
    if (accepted && !fetch.resp_valid) begin
      outstanding_n = outstanding_q + outstanding_cnt_t'(1);
    end else if (!accepted && fetch.resp_valid) begin
      outstanding_n = outstanding_q - outstanding_cnt_t'(1);
    end
    n_flush_n = n_flush_q;
    if (branch_i) begin
      // Everything granted before this cycle is stale
      n_flush_n = outstanding_q - outstanding_cnt_t'(fetch.resp_valid);
    end else if (fetch.resp_valid && (n_flush_q != '0)) begin
      n_flush_n = n_flush_q - outstanding_cnt_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q        <= BOOT_ADDR;
      valid_q       <= '0;
      aligned_q     <= !BOOT_ADDR[1];
      complete_q    <= BOOT_ADDR[1];
      fifo_cnt_q    <= '0;
      outstanding_q <= '0;
      n_flush_q     <= '0;
      req_hold_q    <= 1'b0;
      br_wait_q     <= 1'b0;
    end else begin
      if (branch_i) begin
        addr_q  <= {branch_addr_i[31:1], 1'b0};
        valid_q <= '0;
      end else begin
        addr_q  <= addr_n;
        valid_q <= valid_n;
      end
      aligned_q     <= aligned_n;
      complete_q    <= complete_n;
      fifo_cnt_q    <= fifo_cnt_n;
      outstanding_q <= outstanding_n;
      n_flush_q     <= n_flush_n;
      // Branch still waiting for the bus
      br_wait_q  <= fetch.fetch_valid && !fetch.fetch_ready && (branch_i || br_wait_q);
      req_hold_q <= fetch.fetch_valid && !fetch.fetch_ready && !(branch_i || br_wait_q);
    end
  end

  // Word payload
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
  end

endmodule

// ==== rtl/prefetcher.sv ====
`include "fetch_macros.svh"

module prefetcher import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  fetch_if.pf_mp      fetch,
  output logic        mem_req_o,
  output fetch_addr_t mem_addr_o,
  input  logic        mem_gnt_i,
  input  logic        mem_rvalid_i,
  input  instr_word_t mem_rdata_i
);

  localparam fetch_addr_t BOOT_ADDR = `FETCH_BOOT_ADDR;

  // Next word to fetch, or a branch target not yet granted
  fetch_addr_t      next_q;
  logic             held_q;

  // Granted transactions still waiting for rvalid
  outstanding_cnt_t occ_q;
  logic             occ_full;
  logic             granted;

  // Stop issuing before the in-flight counter wraps
  assign occ_full = (occ_q == '1);

  // Held branch goes out before any new sequential word
  assign mem_req_o  = (fetch.fetch_valid || held_q) && !occ_full;
  assign mem_addr_o = fetch.fetch_branch ? fetch.fetch_branch_addr : next_q;

  assign granted           = mem_req_o && mem_gnt_i;
  assign fetch.fetch_ready = granted;

  // Responses pass straight back
  assign fetch.resp_valid = mem_rvalid_i;
  assign fetch.resp_rdata = mem_rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_q <= {BOOT_ADDR[31:2], 2'b00};
      held_q <= 1'b0;
    end else if (fetch.fetch_branch) begin
      // New target replaces whatever was waiting
      next_q <= granted ? fetch.fetch_branch_addr + 32'd4 : fetch.fetch_branch_addr;
      held_q <= !granted;
    end else if (granted) begin
      next_q <= next_q + 32'd4;
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ_q <= '0;
    end else begin
      case ({granted, mem_rvalid_i})
        2'b10:   occ_q <= occ_q + outstanding_cnt_t'(1);
        2'b01:   occ_q <= occ_q - outstanding_cnt_t'(1);
        default: occ_q <= occ_q;
      endcase
    end
  end

endmodule

// ==== rtl/fetch_unit.sv ====
module fetch_unit import fetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Core control
  input  logic        branch_i,
  input  fetch_addr_t branch_addr_i,
  input  logic        prefetch_en_i,
  output logic        busy_o,

  // Instruction bus
  output logic        mem_req_o,
  output fetch_addr_t mem_addr_o,
  input  logic        mem_gnt_i,
  input  logic        mem_rvalid_i,
  input  instr_word_t mem_rdata_i,

  // Instruction stream
  output logic        instr_valid_o,
  input  logic        instr_ready_i,
  output instr_word_t instr_o,
  output fetch_addr_t instr_pc_o
);

  fetch_if fetch0 ();

  alignment_buffer align0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .prefetch_en_i (prefetch_en_i),
    .branch_addr_i (branch_addr_i),
    .fetch         (fetch0.align_mp),
    .busy_o        (busy_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o)
  );

  // Bus side goes straight to the prefetcher
  prefetcher pf0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch        (fetch0.pf_mp),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

// ==== verification/tb_fetch_unit.sv ====
`include "fetch_macros.svh"

module tb_fetch_unit import fetch_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int SEED            = 32'h0d02_d2ee;
  localparam int ITEMS_STRAIGHT  = 1500;
  localparam int ITEMS_BRANCH    = 2500;
  localparam int ITEMS_FINAL     = 1000;
  localparam int TOTAL_ITEMS     = ITEMS_STRAIGHT + ITEMS_BRANCH + ITEMS_FINAL;
  localparam int WATCHDOG_CYCLES = 60 * TOTAL_ITEMS + 2000;

  logic        clk = 1'b0;
  logic        rst_n = 1'b1;
  logic        branch_i, prefetch_en_i, busy_o;
  fetch_addr_t branch_addr_i;
  logic        mem_req_o, mem_gnt_i, mem_rvalid_i;
  fetch_addr_t mem_addr_o, instr_pc_o;
  instr_word_t mem_rdata_i, instr_o;
  logic        instr_valid_o, instr_ready_i;

  // Bus transactions granted and not yet answered, oldest first
  fetch_addr_t pend_addr [$];
  int          pend_due [$];
  bit          pend_stale [$];
  int          last_due = -1;
  int          cyc = 0;

  // Reference model and bookkeeping
  fetch_addr_t exp_pc = `FETCH_BOOT_ADDR;
  int          taken = 0;
  bit          stalled = 1'b0;
  bit          br_pending = 1'b0;
  bit          idle_seen = 1'b0;
  fetch_addr_t stall_pc;
  instr_word_t stall_instr;
  int          value_errs = 0;
  int          proto_errs = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fetch_unit dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .prefetch_en_i (prefetch_en_i),
    .busy_o        (busy_o),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o)
  );

  //////////////////////////////////////////////////
  // Memory content and compare helpers
  //////////////////////////////////////////////////

  // Fixed hash of the word address
  // Each halfword is compressed about half the time
  function automatic instr_word_t word_at(fetch_addr_t addr);
    logic [31:0] h;
    h = {2'b00, addr[31:2]} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h2c1b_3c6d;
    h = h ^ (h >> 12);
    word_at        = h;
    word_at[1:0]   = h[8] ? 2'b11 : {1'b0, h[9]};
    word_at[17:16] = h[10] ? 2'b11 : {h[11], 1'b0};
  endfunction

  function automatic logic [15:0] half_at(fetch_addr_t addr);
    instr_word_t w;
    w = word_at(addr);
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // Upper half of a compressed item carries no meaning
  function automatic instr_word_t mask_compressed(instr_word_t w);
    return (w[1:0] != 2'b11) ? {16'h0000, w[15:0]} : w;
  endfunction

  task automatic check_instr(input string name, input instr_word_t exp, input instr_word_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR t=%0t %s expected %08h actual %08h", $time, name, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input fetch_addr_t exp, input fetch_addr_t act);
    if (act !== exp) begin
      value_errs++;
      $display("ERR t=%0t %s expected %08h actual %08h", $time, name, exp, act);
    end
  endtask

  task automatic report_protocol(input string msg);
    proto_errs++;
    $display("t=%0t %s", $time, msg);
  endtask

  //////////////////////////////////////////////////
  // Stimulus on the falling edge
  //////////////////////////////////////////////////

  task automatic drive_cycle(input int br_pct, input logic en);
    @(negedge clk);
    prefetch_en_i = en;
    mem_gnt_i     = $urandom_range(0, 99) < 60;
    instr_ready_i = $urandom_range(0, 99) < 70;
    branch_i      = 1'b0;
    if ($urandom_range(0, 99) < br_pct) begin
      branch_i      = 1'b1;
      branch_addr_i = $urandom & 32'h0000_3ffe;
    end
    // Oldest response goes out once its latency has passed
    if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = word_at(pend_addr.pop_front());
      pend_due.delete(0);
      pend_stale.delete(0);
    end else begin
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = $urandom;
    end
  endtask

  task automatic run_until(input int target, input int br_pct);
    while (taken < target) begin
      drive_cycle(br_pct, 1'b1);
    end
  endtask

  initial begin : stimulus
    int seed_ret;
    int wait_cnt;
    seed_ret      = $urandom(SEED);
    branch_i      = 1'b0;
    branch_addr_i = '0;
    prefetch_en_i = 1'b0;
    mem_gnt_i     = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    instr_ready_i = 1'b0;
    #(CLK_PERIOD / 4);
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Straight-line run, then branches at random times
    run_until(ITEMS_STRAIGHT, 0);
    run_until(ITEMS_STRAIGHT + ITEMS_BRANCH, 4);

    // Prefetch off until the bus goes quiet
    drive_cycle(0, 1'b0);
    idle_seen = 1'b0;
    wait_cnt  = 0;
    while (!idle_seen && wait_cnt < 60) begin
      drive_cycle(0, 1'b0);
      wait_cnt++;
    end
    if (!idle_seen) begin
      report_protocol("busy_o stayed high with prefetch disabled");
    end

    // Branch alone must still reach the bus
    drive_cycle(100, 1'b0);
    run_until(TOTAL_ITEMS, 4);

    $display("Checked %0d instructions: %0d value errors, %0d protocol errors",
             taken, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // Monitor and reference model
  //////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    logic [15:0] hw;
    instr_word_t exp_i;
    instr_word_t act_i;
    int          live;
    int          lat;
    cyc = cyc + 1;
    if (!rst_n) begin
      if (mem_req_o || instr_valid_o || busy_o) begin
        report_protocol("outputs not idle during reset");
      end
    end else begin
      // Held item must not move until taken
      if (stalled && !branch_i) begin
        if (!instr_valid_o) begin
          report_protocol("instruction withdrawn while stalled");
        end else if (instr_pc_o !== stall_pc || mask_compressed(instr_o) !== stall_instr) begin
          report_protocol("instruction changed while stalled");
        end
      end
      if (branch_i && instr_valid_o) begin
        report_protocol("instr_valid_o high in a branch cycle");
      end
      if (instr_valid_o && instr_ready_i) begin
        hw = half_at(exp_pc);
        if (hw[1:0] != 2'b11) begin
          exp_i = {16'h0000, hw};
          act_i = {16'h0000, instr_o[15:0]};
        end else begin
          // May span two memory words
          exp_i = {half_at(exp_pc + 32'd2), hw};
          act_i = instr_o;
        end
        check_pc("instr_pc_o", exp_pc, instr_pc_o);
        check_instr("instr_o", exp_i, act_i);
        exp_pc = exp_pc + ((hw[1:0] != 2'b11) ? 32'd2 : 32'd4);
        taken  = taken + 1;
      end
      stalled     = instr_valid_o && !instr_ready_i;
      stall_pc    = instr_pc_o;
      stall_instr = mask_compressed(instr_o);

      // Everything still in flight is stale after a branch
      if (branch_i) begin
        exp_pc = branch_addr_i;
        for (int i = 0; i < pend_stale.size(); i++) begin
          pend_stale[i] = 1'b1;
        end
      end

      if (!prefetch_en_i && !branch_i && !br_pending && mem_req_o) begin
        report_protocol("mem_req_o raised with prefetch disabled and no branch");
      end
      if (!prefetch_en_i && branch_i && !mem_req_o) begin
        report_protocol("branch did not raise mem_req_o with prefetch disabled");
      end
      if (!busy_o && pend_addr.size() > 0) begin
        report_protocol("busy_o low while bus responses were still due");
      end
      if (mem_req_o && mem_addr_o[1:0] != 2'b00) begin
        report_protocol("mem_addr_o not word aligned");
      end
      idle_seen = !busy_o;

      // Branch not granted in its own cycle stays on the bus
      if (branch_i) begin
        br_pending = !(mem_req_o && mem_gnt_i);
      end else if (mem_req_o && mem_gnt_i) begin
        br_pending = 1'b0;
      end

      // Accepted request, answered in order after 1 to 4 cycles
      if (mem_req_o && mem_gnt_i) begin
        lat = $urandom_range(1, 4);
        pend_addr.push_back(mem_addr_o);
        pend_due.push_back((cyc + lat - 1 > last_due) ? cyc + lat - 1 : last_due + 1);
        last_due = pend_due[$];
        pend_stale.push_back(1'b0);
      end
      live = 0;
      foreach (pend_stale[i]) begin
        if (!pend_stale[i]) begin
          live++;
        end
      end
      if (live > `FETCH_MAX_OUTSTANDING) begin
        report_protocol("more than two non-flushed transactions in flight");
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired with %0d of %0d instructions taken", taken, TOTAL_ITEMS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== fetch_unit.f ====
+incdir+common
common/fetch_pkg.sv
common/fetch_if.sv
rtl/alignment_buffer/alignment_buffer.sv
rtl/prefetcher.sv
rtl/fetch_unit.sv
verification/tb_fetch_unit.sv

// ==== Makefile ====
TOP := tb_fetch_unit
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f fetch_unit.f --top-module $(TOP) \
		--Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
